/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_piano_ui
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o sim_$(TOP)
	$(BUILD_DIR)/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/piano_ui_pkg.sv */
package piano_ui_pkg;

	// UI modes, 4-bit code shown on the mode LEDs
	typedef enum logic [3:0] {
		WELCOME,
		CHOOSE,
		FREE,
		SETTING,
		SONG_PLAY,
		SONG_LEARN,
		SONG_GAME,
		PLAY,
		LEARN,
		GAME,
		RANKING
	} mode_e;

	typedef struct packed {
		logic center;
		logic up;
		logic down;
		logic left;
		logic right;
		logic esc;
	} nav_btn_t;

	localparam int NUM_KEYS = 8;

	typedef logic [NUM_KEYS-1:0] note_keys_t;
	typedef logic [2:0]          note_idx_t;
	// Page bit, then slot
	typedef logic [2:0]          song_id_t;
	// 0 is admin
	typedef logic [2:0]          user_id_t;

	localparam user_id_t SONG_OWNER [8] = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd1, 3'd2, 3'd3};

	// Board debounce time in slow_clk cycles
	localparam int DEBOUNCE_DEFAULT = 16;

endpackage

/* common/seg_pkg.sv */
package seg_pkg;

	// Segments a b c d e f g dp, MSB first, active high
	typedef logic [7:0] glyph_t;

	typedef struct packed {
		glyph_t d7;
		glyph_t d6;
		glyph_t d5;
		glyph_t d4;
		glyph_t d3;
		glyph_t d2;
		glyph_t d1;
		glyph_t d0;
	} glyph_row_t;

	localparam glyph_t GLYPH_BLANK = 8'h00;
	localparam glyph_t GLYPH_H     = 8'h6E;
	localparam glyph_t GLYPH_E     = 8'h9E;
	localparam glyph_t GLYPH_L     = 8'h1C;
	localparam glyph_t GLYPH_O     = 8'hFC;
	localparam glyph_t GLYPH_C     = 8'h9C;
	localparam glyph_t GLYPH_S     = 8'hB6;
	localparam glyph_t GLYPH_N     = 8'hEC;
	localparam glyph_t GLYPH_G     = 8'hBC;

	localparam glyph_t GLYPH_DIGIT [10] = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66,
		8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6};

endpackage

/* compile.f */
common/piano_ui_pkg.sv
common/seg_pkg.sv
hdl/key_debouncer.sv
menu/menu_fsm.sv
menu/key_remap.sv
menu/song_selector.sv
display/tube_text.sv
display/tube_scan.sv
hdl/piano_ui_top.sv
testbench/tb_clock.sv
testbench/tb_piano_ui.sv

/* display/tube_scan.sv */
module tube_scan #(
	parameter int SCAN_DIV = 4
) (
	input  logic                slow_clk,
	input  logic                rst_n,
	input  seg_pkg::glyph_row_t row,
	output logic [7:0]          tub_sel,
	output logic [7:0]          tub_data1,
	output logic [7:0]          tub_data2
);
	import seg_pkg::*;

	localparam int DW = $clog2(SCAN_DIV + 1);

	logic [DW-1:0] div_cnt;
	logic [63:0]   row_bits;
	glyph_t        cur;

	assign row_bits = row;

	// Digit select rotates 0 up to 7
	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tub_sel <= 8'h01;
		end else if (div_cnt == DW'(SCAN_DIV - 1)) begin
			div_cnt <= '0;
			tub_sel <= {tub_sel[6:0], tub_sel[7]};
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_comb begin
		cur = '0;
		for (int i = 0; i < 8; i++) begin
			if (tub_sel[i]) cur = cur | row_bits[i*8 +: 8];
		end
	end

	// Upper four digits on bus 1, lower four on bus 2
	assign tub_data1 = (|tub_sel[7:4]) ? cur : 8'h00;
	assign tub_data2 = (|tub_sel[3:0]) ? cur : 8'h00;

	a_sel_onehot: assert property (@(posedge slow_clk) disable iff (!rst_n)
		$onehot(tub_sel));

endmodule

/* display/tube_text.sv */
module tube_text (
	input  logic                   slow_clk,
	input  logic                   rst_n,
	input  piano_ui_pkg::mode_e    mode,
	input  piano_ui_pkg::song_id_t song_id,
	output seg_pkg::glyph_row_t    row
);
	import piano_ui_pkg::*;
	import seg_pkg::*;

	localparam glyph_row_t HELLO_ROW = '{GLYPH_H, GLYPH_E, GLYPH_L, GLYPH_L,
		GLYPH_O, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK};

	glyph_row_t row_d;

	always_comb begin
		case (mode)
			WELCOME: row_d = HELLO_ROW;
			CHOOSE:  row_d = '{GLYPH_C, GLYPH_H, GLYPH_O, GLYPH_O,
				GLYPH_S, GLYPH_E, GLYPH_BLANK, GLYPH_BLANK};
			// Songs are shown numbered from 1
			SONG_PLAY, SONG_LEARN, SONG_GAME, PLAY, LEARN, GAME:
				row_d = '{GLYPH_S, GLYPH_O, GLYPH_N, GLYPH_G, GLYPH_BLANK, GLYPH_BLANK,
					GLYPH_DIGIT[0], GLYPH_DIGIT[{1'b0, song_id} + 4'd1]};
			default: row_d = '0;
		endcase
	end

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			row <= HELLO_ROW;
		end else begin
			row <= row_d;
		end
	end

endmodule

/* hdl/key_debouncer.sv */
module key_debouncer #(
	parameter int WIDTH           = 1,
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  logic             slow_clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] raw,
	output logic [WIDTH-1:0] level,
	output logic [WIDTH-1:0] rise
);
	localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CW-1:0] LAST = CW'(DEBOUNCE_CYCLES - 1);

	// Cycles the raw bit has differed from its level
	logic [CW-1:0] cnt [WIDTH];

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= '0;
			rise  <= '0;
			for (int i = 0; i < WIDTH; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < WIDTH; i++) begin
				rise[i] <= 1'b0;
				if (raw[i] == level[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == LAST) begin
					cnt[i]   <= '0;
					level[i] <= raw[i];
					rise[i]  <= raw[i];
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	// Pulse only on the cycle the level turns high
	a_rise_edge: assert property (@(posedge slow_clk) disable iff (!rst_n)
		(rise & ~(level & ~$past(level))) == '0);

endmodule

/* hdl/piano_ui_top.sv */
module piano_ui_top #(
	parameter int DEBOUNCE_CYCLES = piano_ui_pkg::DEBOUNCE_DEFAULT,
	parameter int SCAN_DIV        = 4
) (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  piano_ui_pkg::nav_btn_t   nav_raw,
	input  piano_ui_pkg::note_keys_t keys_raw,
	input  piano_ui_pkg::user_id_t   user_id,
	output logic [7:0]               mode_led,
	output piano_ui_pkg::song_id_t   song_id,
	output piano_ui_pkg::note_keys_t note_out,
	output logic [7:0]               tub_sel,
	output logic [7:0]               tub_data1,
	output logic [7:0]               tub_data2
);
	import piano_ui_pkg::*;
	import seg_pkg::*;

	nav_btn_t   nav_rise;
	note_keys_t key_level;
	note_keys_t key_rise;
	mode_e      mode;
	logic       song_visible;
	logic       remap_done;
	logic       setting_active;
	logic       list_active;
	glyph_row_t row;

	assign mode_led = {4'b0000, mode};

	key_debouncer #(.WIDTH($bits(nav_btn_t)), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) nav_db (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.raw      (nav_raw),
		.level    (),
		.rise     (nav_rise)
	);

	key_debouncer #(.WIDTH(NUM_KEYS), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) key_db (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.raw      (keys_raw),
		.level    (key_level),
		.rise     (key_rise)
	);

	menu_fsm menu0 (
		.slow_clk       (slow_clk),
		.rst_n          (rst_n),
		.nav_rise       (nav_rise),
		.song_visible   (song_visible),
		.remap_done     (remap_done),
		.mode           (mode),
		.setting_active (setting_active),
		.list_active    (list_active)
	);

	key_remap remap0 (
		.slow_clk       (slow_clk),
		.rst_n          (rst_n),
		.setting_active (setting_active),
		.key_level      (key_level),
		.key_rise       (key_rise),
		.remap_done     (remap_done),
		.note_out       (note_out)
	);

	song_selector songs0 (
		.slow_clk     (slow_clk),
		.rst_n        (rst_n),
		.list_active  (list_active),
		.nav_rise     (nav_rise),
		.user_id      (user_id),
		.song_id      (song_id),
		.song_visible (song_visible)
	);

	tube_text text0 (
		.slow_clk (slow_clk),
		.rst_n    (rst_n),
		.mode     (mode),
		.song_id  (song_id),
		.row      (row)
	);

	tube_scan #(.SCAN_DIV(SCAN_DIV)) scan0 (
		.slow_clk  (slow_clk),
		.rst_n     (rst_n),
		.row       (row),
		.tub_sel   (tub_sel),
		.tub_data1 (tub_data1),
		.tub_data2 (tub_data2)
	);

endmodule

/* menu/key_remap.sv */
module key_remap (
	input  logic                     slow_clk,
	input  logic                     rst_n,
	input  logic                     setting_active,
	input  piano_ui_pkg::note_keys_t key_level,
	input  piano_ui_pkg::note_keys_t key_rise,
	output logic                     remap_done,
	output piano_ui_pkg::note_keys_t note_out
);
	import piano_ui_pkg::*;

	note_idx_t count;
	note_idx_t scratch   [NUM_KEYS];
	note_idx_t scratch_d [NUM_KEYS];
	note_idx_t commit_tbl [NUM_KEYS];
	logic      capture;

	assign capture = setting_active && !remap_done && $onehot(key_rise);

	// Scratch table with the pressed key taking the current count
	always_comb begin
		for (int i = 0; i < NUM_KEYS; i++) begin
			scratch_d[i] = key_rise[i] ? count : scratch[i];
		end
	end

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			count      <= '0;
			remap_done <= 1'b0;
			for (int i = 0; i < NUM_KEYS; i++) begin
				scratch[i]    <= '0;
				commit_tbl[i] <= note_idx_t'(i);
			end
		end else begin
			remap_done <= 1'b0;
			if (!setting_active) begin
				count <= '0;
				for (int i = 0; i < NUM_KEYS; i++) begin
					scratch[i] <= '0;
				end
			end else if (capture) begin
				scratch <= scratch_d;
				count   <= count + 1'b1;
				// Eighth key commits the new table
				if (count == note_idx_t'(NUM_KEYS - 1)) begin
					commit_tbl <= scratch_d;
					remap_done <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		note_out = '0;
		for (int j = 0; j < NUM_KEYS; j++) begin
			note_out[commit_tbl[j]] = note_out[commit_tbl[j]] | key_level[j];
		end
	end

	a_done_in_setting: assert property (@(posedge slow_clk) disable iff (!rst_n)
		remap_done |-> setting_active);

endmodule

/* menu/menu_fsm.sv */
module menu_fsm (
	input  logic                   slow_clk,
	input  logic                   rst_n,
	input  piano_ui_pkg::nav_btn_t nav_rise,
	input  logic                   song_visible,
	input  logic                   remap_done,
	output piano_ui_pkg::mode_e    mode,
	output logic                   setting_active,
	output logic                   list_active
);
	import piano_ui_pkg::*;

	mode_e mode_q;
	mode_e mode_d;
	mode_e cursor_q;
	mode_e cursor_d;
	logic  single;

	// Ignore chords of nav buttons
	assign single = $onehot(nav_rise);

	always_comb begin
		mode_d   = mode_q;
		cursor_d = cursor_q;
		case (mode_q)
			WELCOME: begin
				if (single && nav_rise.center) begin
					mode_d   = CHOOSE;
					cursor_d = FREE;
				end
			end
			CHOOSE: begin
				if (single && nav_rise.center) begin
					mode_d = cursor_q;
				end else if (single && nav_rise.esc) begin
					mode_d = WELCOME;
				end else if (single && nav_rise.up) begin
					case (cursor_q)
						FREE:       cursor_d = SETTING;
						SONG_PLAY:  cursor_d = RANKING;
						SONG_LEARN: cursor_d = FREE;
						SONG_GAME:  cursor_d = SONG_PLAY;
						SETTING:    cursor_d = SONG_LEARN;
						RANKING:    cursor_d = SONG_GAME;
						default:    cursor_d = cursor_q;
					endcase
				end else if (single && nav_rise.down) begin
					case (cursor_q)
						FREE:       cursor_d = SONG_LEARN;
						SONG_PLAY:  cursor_d = SONG_GAME;
						SONG_LEARN: cursor_d = SETTING;
						SONG_GAME:  cursor_d = RANKING;
						SETTING:    cursor_d = FREE;
						RANKING:    cursor_d = SONG_PLAY;
						default:    cursor_d = cursor_q;
					endcase
				end else if (single && (nav_rise.left || nav_rise.right)) begin
					case (cursor_q)
						FREE:       cursor_d = SONG_PLAY;
						SONG_PLAY:  cursor_d = FREE;
						SONG_LEARN: cursor_d = SONG_GAME;
						SONG_GAME:  cursor_d = SONG_LEARN;
						SETTING:    cursor_d = RANKING;
						RANKING:    cursor_d = SETTING;
						default:    cursor_d = cursor_q;
					endcase
				end
			end
			SONG_PLAY, SONG_LEARN, SONG_GAME: begin
				if (single && nav_rise.center && song_visible) begin
					mode_d = (mode_q == SONG_PLAY) ? PLAY :
						(mode_q == SONG_LEARN) ? LEARN : GAME;
				end else if (single && nav_rise.esc) begin
					mode_d = CHOOSE;
				end
			end
			PLAY:    if (single && nav_rise.esc) mode_d = SONG_PLAY;
			LEARN:   if (single && nav_rise.esc) mode_d = SONG_LEARN;
			GAME:    if (single && nav_rise.esc) mode_d = SONG_GAME;
			SETTING: if (remap_done || (single && nav_rise.esc)) mode_d = CHOOSE;
			default: if (single && nav_rise.esc) mode_d = CHOOSE;
		endcase
	end

	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q   <= WELCOME;
			cursor_q <= FREE;
		end else begin
			mode_q   <= mode_d;
			cursor_q <= cursor_d;
		end
	end

	assign mode           = mode_q;
	assign setting_active = (mode_q == SETTING);
	assign list_active    = (mode_q inside {SONG_PLAY, SONG_LEARN, SONG_GAME});

	a_mode_legal: assert property (@(posedge slow_clk) disable iff (!rst_n)
		mode_q inside {[WELCOME:RANKING]});

endmodule

/* menu/song_selector.sv */
module song_selector (
	input  logic                   slow_clk,
	input  logic                   rst_n,
	input  logic                   list_active,
	input  piano_ui_pkg::nav_btn_t nav_rise,
	input  piano_ui_pkg::user_id_t user_id,
	output piano_ui_pkg::song_id_t song_id,
	output logic                   song_visible
);
	import piano_ui_pkg::*;

	logic       page;
	logic [1:0] slot;
	user_id_t   owner;

	// Slot wraps within a page of four
	always_ff @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			page <= 1'b0;
			slot <= 2'd0;
		end else if (list_active) begin
			if (nav_rise.up) begin
				slot <= slot - 1'b1;
			end else if (nav_rise.down) begin
				slot <= slot + 1'b1;
			end else if (nav_rise.left || nav_rise.right) begin
				page <= ~page;
			end
		end
	end

	assign song_id      = {page, slot};
	assign owner        = SONG_OWNER[song_id];
	// Admin songs are visible to everyone
	assign song_visible = (owner == '0) || (owner == user_id);

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
	output logic slow_clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial slow_clk = 1'b0;
	always #4 slow_clk = ~slow_clk;

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge slow_clk);
		rst_n <= 1'b1;
	end

endmodule

/* testbench/tb_piano_ui.sv */
module tb_piano_ui;
	timeunit 1ns;
	timeprecision 100ps;
	import piano_ui_pkg::*;
	import seg_pkg::*;

	localparam int DEBOUNCE = 4;
	localparam int SCAN_DIV = 4;
	localparam int unsigned SEED = 15673;
	// Bit positions in nav_btn_t
	localparam int B_ESC    = 0;
	localparam int B_RIGHT  = 1;
	localparam int B_LEFT   = 2;
	localparam int B_DOWN   = 3;
	localparam int B_UP     = 4;
	localparam int B_CENTER = 5;

	logic       slow_clk;
	logic       rst_n;
	nav_btn_t   nav_raw;
	note_keys_t keys_raw;
	user_id_t   user_id;
	logic [7:0] mode_led;
	song_id_t   song_id;
	note_keys_t note_out;
	logic [7:0] tub_sel;
	logic [7:0] tub_data1;
	logic [7:0] tub_data2;

	int unsigned rng_state = SEED;
	int errors = 0;
	int checks = 0;
	int test_err0 = 0;
	int perm [8];

	// Reference model state
	mode_e m_mode = WELCOME;
	int cur_row = 0;
	int cur_col = 0;
	int m_page = 0;
	int m_slot = 0;
	int m_user = 0;
	int m_count = 0;
	int m_scratch [8];
	int m_commit [8];
	int scan_cycles;

	tb_clock clk0 (
		.slow_clk (slow_clk),
		.rst_n    (rst_n)
	);

	piano_ui_top #(.DEBOUNCE_CYCLES(DEBOUNCE), .SCAN_DIV(SCAN_DIV)) dut0 (
		.slow_clk  (slow_clk),
		.rst_n     (rst_n),
		.nav_raw   (nav_raw),
		.keys_raw  (keys_raw),
		.user_id   (user_id),
		.mode_led  (mode_led),
		.song_id   (song_id),
		.note_out  (note_out),
		.tub_sel   (tub_sel),
		.tub_data1 (tub_data1),
		.tub_data2 (tub_data2)
	);

	// Scan digit advances every SCAN_DIV cycles after reset
	always @(posedge slow_clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cycles <= 0;
		end else begin
			scan_cycles <= scan_cycles + 1;
		end
	end

	function automatic int unsigned lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return lcg_next() % n;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		if (errors == test_err0) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	// Choose page is three rows of two entries
	function automatic mode_e grid_mode(input int r, input int c);
		case (r)
			0:       return (c == 0) ? FREE : SONG_PLAY;
			1:       return (c == 0) ? SONG_LEARN : SONG_GAME;
			default: return (c == 0) ? SETTING : RANKING;
		endcase
	endfunction

	function automatic int song_num();
		return m_page * 4 + m_slot;
	endfunction

	// Songs 5 to 7 belong to users 1 to 3
	function automatic bit visible(input int song, input int user);
		if (song < 5) begin
			return 1'b1;
		end
		return user == song - 4;
	endfunction

	task automatic apply_nav(input int b);
		case (m_mode)
			WELCOME: begin
				if (b == B_CENTER) begin
					m_mode = CHOOSE;
					cur_row = 0;
					cur_col = 0;
				end
			end
			CHOOSE: begin
				if (b == B_CENTER) begin
					m_mode = grid_mode(cur_row, cur_col);
				end else if (b == B_ESC) begin
					m_mode = WELCOME;
				end else if (b == B_UP) begin
					cur_row = (cur_row + 2) % 3;
				end else if (b == B_DOWN) begin
					cur_row = (cur_row + 1) % 3;
				end else begin
					cur_col = 1 - cur_col;
				end
			end
			SONG_PLAY, SONG_LEARN, SONG_GAME: begin
				if (b == B_CENTER) begin
					if (visible(song_num(), m_user)) begin
						m_mode = (m_mode == SONG_PLAY) ? PLAY :
							(m_mode == SONG_LEARN) ? LEARN : GAME;
					end
				end else if (b == B_ESC) begin
					m_mode = CHOOSE;
				end else if (b == B_UP) begin
					m_slot = (m_slot + 3) % 4;
				end else if (b == B_DOWN) begin
					m_slot = (m_slot + 1) % 4;
				end else begin
					m_page = 1 - m_page;
				end
			end
			PLAY, LEARN, GAME: begin
				if (b == B_ESC) begin
					m_mode = (m_mode == PLAY) ? SONG_PLAY :
						(m_mode == LEARN) ? SONG_LEARN : SONG_GAME;
				end
			end
			default: begin
				if (b == B_ESC) begin
					m_mode = CHOOSE;
					m_count = 0;
				end
			end
		endcase
	endtask

	task automatic apply_key(input int k);
		if (m_mode == SETTING) begin
			m_scratch[k] = m_count;
			m_count++;
			if (m_count == NUM_KEYS) begin
				m_commit = m_scratch;
				m_count = 0;
				m_mode = CHOOSE;
			end
		end
	endtask

	function automatic glyph_t model_glyph(input int d);
		logic [63:0] bits;
		bits = '0;
		case (m_mode)
			WELCOME: bits = {GLYPH_H, GLYPH_E, GLYPH_L, GLYPH_L, GLYPH_O, {3{GLYPH_BLANK}}};
			CHOOSE:  bits = {GLYPH_C, GLYPH_H, GLYPH_O, GLYPH_O, GLYPH_S, GLYPH_E, {2{GLYPH_BLANK}}};
			SONG_PLAY, SONG_LEARN, SONG_GAME, PLAY, LEARN, GAME:
				bits = {GLYPH_S, GLYPH_O, GLYPH_N, GLYPH_G, {2{GLYPH_BLANK}},
					GLYPH_DIGIT[0], GLYPH_DIGIT[song_num() + 1]};
			default: bits = '0;
		endcase
		return bits[d*8 +: 8];
	endfunction

	task automatic wait_mode(input mode_e exp);
		int n;
		n = 0;
		while (mode_led !== 8'(exp) && n < 40) begin
			@(negedge slow_clk);
			n++;
		end
		if (mode_led !== 8'(exp)) begin
			$display("Timeout at %0t ns: mode_led never reached %s", $time, exp.name());
			errors++;
		end
	endtask

	// Hold 6 cycles, release 6
	task automatic press_nav(input int b);
		@(posedge slow_clk);
		nav_raw <= nav_btn_t'(6'(1 << b));
		repeat (6) @(posedge slow_clk);
		nav_raw <= '0;
		repeat (6) @(posedge slow_clk);
		@(negedge slow_clk);
	endtask

	task automatic press_and_check(input int b);
		press_nav(b);
		apply_nav(b);
		wait_mode(m_mode);
		check_eq("mode_led", 32'(mode_led), 32'(m_mode));
		check_eq("song_id", 32'(song_id), 32'(song_num()));
	endtask

	task automatic press_key_and_check(input int k);
		@(posedge slow_clk);
		keys_raw <= note_keys_t'(1 << k);
		repeat (6) @(posedge slow_clk);
		keys_raw <= '0;
		repeat (6) @(posedge slow_clk);
		@(negedge slow_clk);
		apply_key(k);
		wait_mode(m_mode);
		check_eq("mode_led", 32'(mode_led), 32'(m_mode));
	endtask

	task automatic go_welcome();
		repeat (3) press_and_check(B_ESC);
	endtask

	task automatic shuffle_keys();
		int j;
		int tmp;
		for (int i = 0; i < 8; i++) begin
			perm[i] = i;
		end
		for (int i = 7; i > 0; i--) begin
			j = rand_below(i + 1);
			tmp = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end
	endtask

	task automatic verify_table();
		int n;
		for (int k = 0; k < NUM_KEYS; k++) begin
			@(posedge slow_clk);
			keys_raw <= note_keys_t'(1 << k);
			n = 0;
			while (note_out === '0 && n < 20) begin
				@(negedge slow_clk);
				n++;
			end
			check_eq("note_out", 32'(note_out), 32'(1 << m_commit[k]));
			@(posedge slow_clk);
			keys_raw <= '0;
			n = 0;
			while (note_out !== '0 && n < 20) begin
				@(negedge slow_clk);
				n++;
			end
			if (note_out !== '0) begin
				$display("Timeout at %0t ns: note_out did not clear after key %0d", $time, k);
				errors++;
			end
		end
	endtask

	// Row register lags mode by one cycle
	task automatic check_display();
		int d;
		glyph_t g;
		@(posedge slow_clk);
		for (int n = 0; n < 8 * SCAN_DIV; n++) begin
			@(negedge slow_clk);
			d = (scan_cycles / SCAN_DIV) % 8;
			g = model_glyph(d);
			check_eq("tub_sel", 32'(tub_sel), 32'(1 << d));
			check_eq("tub_data1", 32'(tub_data1), 32'((d >= 4) ? g : 8'h00));
			check_eq("tub_data2", 32'(tub_data2), 32'((d < 4) ? g : 8'h00));
		end
	endtask

	initial begin
		int n;
		int b;
		nav_raw = '0;
		keys_raw = '0;
		user_id = '0;
		for (int k = 0; k < 8; k++) begin
			m_commit[k] = k;
			m_scratch[k] = 0;
		end
		n = 0;
		while (rst_n !== 1'b1 && n < 50) begin
			@(posedge slow_clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("Reset never released");
			errors++;
		end
		@(negedge slow_clk);

		// Short pulses must be filtered out
		repeat (6) begin
			@(posedge slow_clk);
			b = 1 + rand_below(3);
			nav_raw <= nav_btn_t'(6'(1 << B_CENTER));
			keys_raw <= note_keys_t'(rand_below(255) + 1);
			for (int c = 0; c < b + 6; c++) begin
				@(posedge slow_clk);
				if (c == b - 1) begin
					nav_raw <= '0;
					keys_raw <= '0;
				end
				@(negedge slow_clk);
				check_eq("note_out", 32'(note_out), 32'(0));
				check_eq("mode_led", 32'(mode_led), 32'(WELCOME));
			end
		end
		@(posedge slow_clk);
		nav_raw <= nav_btn_t'(6'(1 << B_CENTER));
		n = 0;
		while (mode_led === 8'(WELCOME) && n < 20) begin
			@(posedge slow_clk);
			n++;
			@(negedge slow_clk);
		end
		check_eq("mode_led latency", 32'(n), 32'(DEBOUNCE + 1));
		repeat (6) @(posedge slow_clk);
		nav_raw <= '0;
		repeat (6) @(posedge slow_clk);
		@(negedge slow_clk);
		apply_nav(B_CENTER);
		wait_mode(m_mode);
		check_eq("mode_led", 32'(mode_led), 32'(m_mode));
		report_test("bounce rejection");

		for (int i = 0; i < 40; i++) begin
			press_and_check(rand_below(6));
		end
		report_test("menu navigation");

		go_welcome();
		press_and_check(B_CENTER);
		press_and_check(B_RIGHT);
		press_and_check(B_CENTER);
		for (int i = 0; i < 30; i++) begin
			m_user = rand_below(8);
			@(posedge slow_clk);
			user_id <= user_id_t'(m_user);
			press_and_check(1 + rand_below(5));
			if (m_mode inside {PLAY, LEARN, GAME}) begin
				press_and_check(B_ESC);
			end
		end
		report_test("song cursor and visibility");

		go_welcome();
		press_and_check(B_CENTER);
		press_and_check(B_UP);
		press_and_check(B_CENTER);
		shuffle_keys();
		for (int i = 0; i < 8; i++) begin
			press_key_and_check(perm[i]);
		end
		verify_table();
		// Partial capture then esc keeps the old table
		press_and_check(B_CENTER);
		shuffle_keys();
		n = 1 + rand_below(7);
		for (int i = 0; i < n; i++) begin
			press_key_and_check(perm[i]);
		end
		press_and_check(B_ESC);
		verify_table();
		report_test("key remapping");

		check_display();
		press_and_check(B_ESC);
		check_display();
		press_and_check(B_CENTER);
		press_and_check(B_CENTER);
		check_display();
		press_and_check(B_ESC);
		press_and_check(B_RIGHT);
		press_and_check(B_CENTER);
		repeat (rand_below(4)) press_and_check(B_DOWN);
		if (rand_below(2) == 1) begin
			press_and_check(B_LEFT);
		end
		check_display();
		report_test("display scan");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
